/* Bender.yml */
package:
  name: rx_control

sources:
  - rx_pkg.sv
  - rx_settings.sv
  - cmd_fifo.sv
  - sample_fifo.sv
  - rx_control.sv
  - rx_top.sv
  - target: simulation
    files:
      - tb_clkgen.sv
      - rx_tb.sv

/* cmd_fifo.sv */
`timescale 1ns/100ps

module cmd_fifo
  (
   input  logic            clk,
   input  logic            rst,
   input  logic            clear_i,
   input  logic            push_i,
   input  rx_pkg::rx_cmd_t data_i,
   input  logic            pop_i,
   output rx_pkg::rx_cmd_t data_o,
   output logic            full_o,
   output logic            empty_o
   );
   import rx_pkg::*;

   rx_cmd_t                   mem [2**cmd_depth_log2];
   logic [cmd_depth_log2-1:0] wr_ptr;
   logic [cmd_depth_log2-1:0] rd_ptr;
   logic [cmd_depth_log2:0]   count;
   logic                      do_push;
   logic                      do_pop;

   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= data_i;
   end

   always_ff @(posedge clk)
   begin
      if (rst || clear_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   assign data_o  = mem[rd_ptr];  // Head is always visible
   assign full_o  = count[cmd_depth_log2];
   assign empty_o = (count == '0);

   a_no_over_under : assert property (@(posedge clk) disable iff (rst)
      !(push_i && full_o) && !(pop_i && empty_o));

endmodule

/* filelist.f */
rx_pkg.sv
rx_settings.sv
cmd_fifo.sv
sample_fifo.sv
rx_control.sv
rx_top.sv
tb_clkgen.sv
rx_tb.sv

/* rx_control.sv */
`timescale 1ns/100ps

module rx_control
  #(parameter int fifo_size = 10)
  (
   input  logic            clk,
   input  logic            rst,
   input  rx_pkg::rx_cmd_t cmd_i,
   input  logic            cmd_push_i,
   input  logic            clear_i,
   input  logic [31:0]     master_time_i,
   input  logic [31:0]     sample_i,
   input  logic            strobe_i,
   output logic            run_o,
   output logic            overrun_o,
   output logic [31:0]     wr_dat_o,
   output logic            wr_write_o,
   output logic            wr_done_o,
   input  logic            wr_ready_i,
   input  logic            wr_full_i,
   output logic [15:0]     fifo_occupied_o,
   output logic            fifo_full_o,
   output logic            fifo_empty_o
   );
   import rx_pkg::*;

   rx_cmd_t     next_cmd;  // Head of command FIFO
   rx_cmd_t     cur_cmd;
   logic        cmd_empty;
   logic        cmd_pop;
   fifo_line_t  line_in;
   fifo_line_t  line_out;
   logic        line_write;
   logic        line_read;
   logic        full;
   logic        empty;
   ibs_state_e  ibs_state;
   xfer_state_e xfer_state;
   logic [20:0] lines_left;
   logic [8:0]  lines_left_frame;
   logic [32:0] delta_time;
   logic        too_late;
   logic        go_now;
   logic        last_line;
   logic        last_in_frame;
   logic        take_sample;
   logic        mid_pkt;  // Drain stopped inside a packet
   logic        discard;

   cmd_fifo u_cmd_fifo
     (
      .clk     (clk),
      .rst     (rst),
      .clear_i (clear_i),
      .push_i  (cmd_push_i),
      .data_i  (cmd_i),
      .pop_i   (cmd_pop),
      .data_o  (next_cmd),
      .full_o  (),
      .empty_o (cmd_empty)
      );

   sample_fifo #(.depth_log2(fifo_size)) u_sample_fifo
     (
      .clk        (clk),
      .rst        (rst),
      .clear_i    (clear_i),
      .write_i    (line_write),
      .data_i     (line_in),
      .read_i     (line_read),
      .data_o     (line_out),
      .full_o     (full),
      .empty_o    (empty),
      .occupied_o (fifo_occupied_o)
      );

   // Negative difference in the top two bits means the time has passed
   assign delta_time    = {1'b0, cur_cmd.rcvtime} - {1'b0, master_time_i};
   assign too_late      = (delta_time[32:31] == 2'b11) & ~cur_cmd.send_imm;
   assign go_now        = cur_cmd.send_imm | (master_time_i == cur_cmd.rcvtime);
   assign last_line     = (lines_left == 21'd1);
   assign last_in_frame = (lines_left_frame == 9'd1);
   assign take_sample   = (ibs_state == ibs_running) & strobe_i & ~full;

   assign cmd_pop = ((ibs_state == ibs_idle) | (take_sample & last_line & cur_cmd.chain))
                    & ~cmd_empty;

   always_ff @(posedge clk)
   begin
      if (cmd_pop)
         cur_cmd <= next_cmd;
   end

   always_ff @(posedge clk)
   begin
      if (rst || clear_i)
      begin
         ibs_state        <= ibs_idle;
         lines_left       <= '0;
         lines_left_frame <= '0;
      end
      else
      begin
         case (ibs_state)
            ibs_idle:
               if (!cmd_empty)
               begin
                  ibs_state        <= ibs_waiting;
                  lines_left       <= next_cmd.numlines;
                  lines_left_frame <= next_cmd.lines_per_frame;
               end
            ibs_waiting:
               if (go_now)
                  ibs_state <= ibs_firstline;
               else if (too_late)
                  ibs_state <= ibs_overrun;
            ibs_firstline:
               if (full || strobe_i)
                  ibs_state <= ibs_overrun;  // No room for header, or strobe collides
               else
                  ibs_state <= ibs_running;
            ibs_running:
               if (strobe_i)
               begin
                  if (full)
                     ibs_state <= ibs_overrun;
                  else if (last_line)
                  begin
                     if (!cur_cmd.chain)
                        ibs_state <= ibs_idle;
                     else if (cmd_empty)
                        ibs_state <= ibs_overrun;
                     else
                     begin
                        ibs_state        <= ibs_firstline;  // Chained, no time wait
                        lines_left       <= next_cmd.numlines;
                        lines_left_frame <= next_cmd.lines_per_frame;
                     end
                  end
                  else if (last_in_frame)
                  begin
                     ibs_state        <= ibs_firstline;
                     lines_left       <= lines_left - 1'b1;
                     lines_left_frame <= cur_cmd.lines_per_frame;
                  end
                  else
                  begin
                     lines_left       <= lines_left - 1'b1;
                     lines_left_frame <= lines_left_frame - 1'b1;
                  end
               end
            ibs_overrun:
               ibs_state <= ibs_overrun;  // Held until clear
            default:
               ibs_state <= ibs_idle;
         endcase
      end
   end

   // Header carries the current time
   assign line_in = (ibs_state == ibs_firstline) ?
                    fifo_line_t'{sop: 1'b1, eop: 1'b0, data: master_time_i} :
                    fifo_line_t'{sop: 1'b0, eop: last_line | last_in_frame, data: sample_i};

   assign line_write = ((ibs_state == ibs_firstline) & ~full) | take_sample;

   assign run_o     = (ibs_state == ibs_running) | (ibs_state == ibs_firstline);
   assign overrun_o = (ibs_state == ibs_overrun);

   always_ff @(posedge clk)
   begin
      if (rst || clear_i)
      begin
         xfer_state <= xfer_idle;
         mid_pkt    <= 1'b0;
      end
      else
      begin
         if (wr_write_o)
            mid_pkt <= ~line_out.eop;
         case (xfer_state)
            xfer_idle:
               if (wr_ready_i)
                  xfer_state <= xfer_go;
            xfer_go:
               if (wr_write_o && (line_out.eop || wr_full_i))
                  xfer_state <= xfer_idle;
            default:
               xfer_state <= xfer_idle;
         endcase
      end
   end

   // Stray lines outside a packet are dropped
   assign discard    = (xfer_state == xfer_idle) & ~empty & ~line_out.sop & ~mid_pkt;
   assign wr_write_o = (xfer_state == xfer_go) & ~empty;
   assign wr_done_o  = wr_write_o & line_out.eop;
   assign wr_dat_o   = line_out.data;
   assign line_read  = wr_write_o | discard;

   assign fifo_full_o  = full;
   assign fifo_empty_o = empty;

   // A full FIFO takes no line, so occupancy cannot grow
   a_no_write_full : assert property (@(posedge clk) disable iff (rst)
      (full && !line_read && !clear_i) |=> (fifo_occupied_o == $past(fifo_occupied_o)));

endmodule

/* rx_pkg.sv */
package rx_pkg;

   // Settings bus addresses of the receive block
   localparam logic [7:0] rx_base       = 8'd160;
   localparam logic [7:0] rx_addr_time  = rx_base + 8'd3;  // Commits a command
   localparam logic [7:0] rx_addr_cmd   = rx_base + 8'd4;
   localparam logic [7:0] rx_addr_clear = rx_base + 8'd5;  // Clears overrun

   localparam int cmd_depth_log2 = 4;

   typedef struct packed
   {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Upper word from the command address, lower word from the time address
   typedef struct packed
   {
      logic        send_imm;
      logic        chain;
      logic [20:0] numlines;
      logic [8:0]  lines_per_frame;
      logic [31:0] rcvtime;
   } rx_cmd_t;

   typedef struct packed
   {
      logic        sop;
      logic        eop;
      logic [31:0] data;
   } fifo_line_t;

   typedef enum logic [2:0]
   {
      ibs_idle,
      ibs_waiting,
      ibs_firstline,
      ibs_running,
      ibs_overrun
   } ibs_state_e;

   typedef enum logic
   {
      xfer_idle,
      xfer_go
   } xfer_state_e;

endpackage

/* rx_settings.sv */
`timescale 1ns/100ps

module rx_settings
  (
   input  logic             clk,
   input  logic             rst,
   input  rx_pkg::set_bus_t set_i,
   output rx_pkg::rx_cmd_t  cmd_o,
   output logic             cmd_push_o,
   output logic             clear_o
   );
   import rx_pkg::*;

   logic [31:0] cmd_q;
   logic [31:0] time_q;
   logic        time_chg;
   logic        clear_q;

   always_ff @(posedge clk)
   begin
      if (set_i.stb && (set_i.addr == rx_addr_cmd))
         cmd_q <= set_i.data;
      if (set_i.stb && (set_i.addr == rx_addr_time))
         time_q <= set_i.data;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         time_chg <= 1'b0;
         clear_q  <= 1'b0;
      end
      else
      begin
         time_chg <= set_i.stb && (set_i.addr == rx_addr_time);
         clear_q  <= set_i.stb && (set_i.addr == rx_addr_clear);
      end
   end

   assign cmd_o      = {cmd_q, time_q};
   assign cmd_push_o = time_chg;  // One push per time write
   assign clear_o    = clear_q;

   a_quiet_after_rst : assert property (@(posedge clk) rst |=> !(cmd_push_o || clear_o));

endmodule

/* rx_tb.sv */
`timescale 1ns/100ps

module rx_tb;
   import rx_pkg::*;

   // Command lengths times strobe spacing, with wide margin
   localparam int max_cycles = 20000;
   localparam int fifo_lines = 64;

   typedef struct packed
   {
      logic       rel;   // Header time taken from the strobe of sample line.data
      fifo_line_t line;
   } exp_line_t;

   logic        clk;
   logic        rst;
   set_bus_t    set_i;
   logic [31:0] master_time_i;
   logic [31:0] sample_i;
   logic        strobe_i;
   logic        run_o;
   logic        overrun_o;
   logic [31:0] wr_dat_o;
   logic        wr_write_o;
   logic        wr_done_o;
   logic        wr_ready_i;
   logic        wr_full_i;
   logic [15:0] fifo_occupied_o;
   logic        fifo_full_o;
   logic        fifo_empty_o;

   exp_line_t   exp_q[$];
   logic [31:0] strobe_time [0:4095];
   logic [31:0] sample_cnt = '0;
   int          strobe_gap = 3;
   logic        run_prev = 1'b0;
   logic        rand_drain = 1'b1;
   integer      seed = 32'h4a6;
   logic [31:0] rnd;
   int          cycle_cnt = 0;
   logic        at_pkt_start = 1'b1;
   exp_line_t   mon_exp;
   fifo_line_t  mon_want;
   fifo_line_t  mon_got;

   tb_clkgen #(.period(4.0), .rst_cycles(16)) u_clkgen
     (
      .clk_o (clk),
      .rst_o (rst)
      );

   rx_top u_dut
     (
      .clk             (clk),
      .rst             (rst),
      .set_i           (set_i),
      .master_time_i   (master_time_i),
      .sample_i        (sample_i),
      .strobe_i        (strobe_i),
      .run_o           (run_o),
      .overrun_o       (overrun_o),
      .wr_dat_o        (wr_dat_o),
      .wr_write_o      (wr_write_o),
      .wr_done_o       (wr_done_o),
      .wr_ready_i      (wr_ready_i),
      .wr_full_i       (wr_full_i),
      .fifo_occupied_o (fifo_occupied_o),
      .fifo_full_o     (fifo_full_o),
      .fifo_empty_o    (fifo_empty_o)
      );

   task automatic check_line(input string name, input fifo_line_t exp, input fifo_line_t act);
      if (exp !== act)
      begin
         $display("ERROR at %0t: %s expected sop=%b eop=%b data=%h, got sop=%b eop=%b data=%h",
                  $time, name, exp.sop, exp.eop, exp.data, act.sop, act.eop, act.data);
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act)
      begin
         $display("ERROR at %0t: %s expected %b got %b", $time, name, exp, act);
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_count(input string name, input logic [15:0] exp, input logic [15:0] act);
      if (exp !== act)
      begin
         $display("ERROR at %0t: %s expected %0d got %0d", $time, name, exp, act);
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   endtask

   // Header, then samples in frames, eop on frame ends and on the last line
   function automatic void expect_cmd(input rx_cmd_t cmd, input logic [31:0] first,
                                      input logic hdr_rel, input logic [31:0] hdr);
      logic frame_end;
      logic last;
      exp_q.push_back('{rel: hdr_rel, line: '{sop: 1'b1, eop: 1'b0, data: hdr}});
      for (int n = 0; n < cmd.numlines; n++)
      begin
         frame_end = ((n + 1) % cmd.lines_per_frame) == 0;
         last      = (n + 1) == cmd.numlines;
         exp_q.push_back('{rel: 1'b0, line: '{sop: 1'b0, eop: frame_end | last, data: first + n}});
         if (frame_end && !last)
            exp_q.push_back('{rel: 1'b1, line: '{sop: 1'b1, eop: 1'b0, data: first + n}});
      end
   endfunction

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      #1 set_i = '{stb: 1'b1, addr: addr, data: data};
      @(posedge clk);
      #1 set_i = '0;
   endtask

   // Header time of a send-immediately command taken by an idle DUT
   task automatic push_cmd(input rx_cmd_t cmd, output logic [31:0] imm_hdr);
      write_setting(rx_addr_cmd, cmd[63:32]);
      @(posedge clk);
      imm_hdr = master_time_i + 32'd5;
      #1 set_i = '{stb: 1'b1, addr: rx_addr_time, data: cmd[31:0]};
      @(posedge clk);
      #1 set_i = '0;
   endtask

   task automatic wait_drained();
      @(posedge clk);
      while (exp_q.size() != 0 || !fifo_empty_o)
      begin
         check_flag("overrun_o", 1'b0, overrun_o);
         @(posedge clk);
      end
   endtask

   task automatic clear_overrun();
      write_setting(rx_addr_clear, 32'd0);
      while (overrun_o)
         @(posedge clk);
      check_flag("fifo_empty_o", 1'b1, fifo_empty_o);
      check_flag("fifo_full_o", 1'b0, fifo_full_o);
      check_count("fifo_occupied_o", 16'd0, fifo_occupied_o);
   endtask

   // Time, DSP strobes and buffer levels
   always @(posedge clk)
   begin
      #1;
      if (strobe_i)
         sample_cnt = sample_cnt + 32'd1;
      master_time_i = master_time_i + 32'd1;
      strobe_i      = 1'b0;
      if (strobe_gap < 3)
         strobe_gap++;
      if (!rst && run_o && run_prev && strobe_gap >= 3)
      begin
         strobe_i   = 1'b1;
         strobe_gap = 0;
         strobe_time[sample_cnt[11:0]] = master_time_i;
      end
      run_prev = run_o;
      sample_i = sample_cnt;
      rnd      = $random(seed);
      wr_ready_i = rand_drain & rnd[0];
      wr_full_i  = rand_drain & (rnd[3:2] == 2'b00);
   end

   // Compare each line written to the buffer
   always @(negedge clk)
   begin
      if (!rst && wr_write_o)
      begin
         if (exp_q.size() == 0)
         begin
            $display("Line %h written at %0t while no line was expected", wr_dat_o, $time);
            $display("SOME TESTS FAILED");
            $fatal(1);
         end
         else
         begin
            mon_exp  = exp_q.pop_front();
            mon_want = mon_exp.line;
            if (mon_exp.rel)
               mon_want.data = strobe_time[mon_exp.line.data[11:0]] + 32'd1;
            mon_got = '{sop: at_pkt_start, eop: wr_done_o, data: wr_dat_o};
            check_line("wr_dat_o/wr_done_o", mon_want, mon_got);
            at_pkt_start = wr_done_o;
         end
      end
   end

   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt >= max_cycles)
      begin
         $display("Run stopped after %0d cycles without finishing the tests", cycle_cnt);
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   end

   initial
   begin
      rx_cmd_t     cmd;
      rx_cmd_t     cmd2;
      logic [31:0] hdr;
      logic [31:0] t_rcv;
      logic [31:0] s0;
      set_i         = '0;
      master_time_i = '0;
      sample_i      = '0;
      strobe_i      = 1'b0;
      wr_ready_i    = 1'b0;
      wr_full_i     = 1'b0;
      @(negedge rst);
      @(posedge clk);
      check_flag("run_o", 1'b0, run_o);
      check_flag("overrun_o", 1'b0, overrun_o);
      check_flag("wr_write_o", 1'b0, wr_write_o);
      check_flag("wr_done_o", 1'b0, wr_done_o);
      check_flag("fifo_empty_o", 1'b1, fifo_empty_o);
      check_flag("fifo_full_o", 1'b0, fifo_full_o);

      // Send-immediately, 7 lines in frames of 3
      s0  = sample_cnt;
      cmd = '{send_imm: 1'b1, chain: 1'b0, numlines: 21'd7, lines_per_frame: 9'd3, rcvtime: '0};
      push_cmd(cmd, hdr);
      expect_cmd(cmd, s0, 1'b0, hdr);
      wait_drained();

      // Timed start
      s0    = sample_cnt;
      t_rcv = master_time_i + 32'd200;
      cmd   = '{send_imm: 1'b0, chain: 1'b0, numlines: 21'd5, lines_per_frame: 9'd4,
                rcvtime: t_rcv};
      push_cmd(cmd, hdr);
      expect_cmd(cmd, s0, 1'b0, t_rcv + 32'd1);
      while (master_time_i <= t_rcv)
      begin
         check_flag("run_o", 1'b0, run_o);
         @(posedge clk);
      end
      wait_drained();

      // Chain of two queued commands
      s0    = sample_cnt;
      t_rcv = master_time_i + 32'd100;
      cmd   = '{send_imm: 1'b0, chain: 1'b1, numlines: 21'd5, lines_per_frame: 9'd2,
                rcvtime: t_rcv};
      cmd2  = '{send_imm: 1'b1, chain: 1'b0, numlines: 21'd4, lines_per_frame: 9'd3,
                rcvtime: '0};
      push_cmd(cmd, hdr);
      push_cmd(cmd2, hdr);
      expect_cmd(cmd, s0, 1'b0, t_rcv + 32'd1);
      expect_cmd(cmd2, s0 + 32'd5, 1'b1, s0 + 32'd4);
      wait_drained();
      check_flag("run_o", 1'b0, run_o);

      // Late command
      t_rcv = master_time_i - 32'd50;
      cmd   = '{send_imm: 1'b0, chain: 1'b0, numlines: 21'd3, lines_per_frame: 9'd3,
                rcvtime: t_rcv};
      push_cmd(cmd, hdr);
      while (!overrun_o)
      begin
         check_flag("run_o", 1'b0, run_o);
         @(posedge clk);
      end
      check_flag("run_o", 1'b0, run_o);
      clear_overrun();

      // Long run under random ready and full
      @(posedge clk);
      s0  = sample_cnt;
      cmd = '{send_imm: 1'b1, chain: 1'b0, numlines: 21'd60, lines_per_frame: 9'd7, rcvtime: '0};
      push_cmd(cmd, hdr);
      expect_cmd(cmd, s0, 1'b0, hdr);
      wait_drained();

      // Sample FIFO fills with the drain stopped
      rand_drain = 1'b0;
      write_setting(rx_addr_clear, 32'd0);  // Drain machine back to idle
      repeat (2) @(posedge clk);
      cmd = '{send_imm: 1'b1, chain: 1'b0, numlines: 21'd100, lines_per_frame: 9'd200,
              rcvtime: '0};
      push_cmd(cmd, hdr);
      while (!fifo_full_o)
      begin
         check_flag("overrun_o", 1'b0, overrun_o);
         @(posedge clk);
      end
      check_count("fifo_occupied_o", 16'(fifo_lines), fifo_occupied_o);
      while (!overrun_o)
         @(posedge clk);
      check_count("fifo_occupied_o", 16'(fifo_lines), fifo_occupied_o);
      check_flag("fifo_full_o", 1'b1, fifo_full_o);
      check_flag("run_o", 1'b0, run_o);
      clear_overrun();

      // Chain with nothing queued
      cmd = '{send_imm: 1'b1, chain: 1'b1, numlines: 21'd4, lines_per_frame: 9'd4, rcvtime: '0};
      push_cmd(cmd, hdr);
      while (!overrun_o)
         @(posedge clk);
      check_flag("run_o", 1'b0, run_o);
      check_count("fifo_occupied_o", 16'd5, fifo_occupied_o);
      clear_overrun();

      repeat (4) @(posedge clk);
      if (exp_q.size() != 0)
      begin
         $display("%0d expected lines were never written", exp_q.size());
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
      else
      begin
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

endmodule

/* rx_top.sv */
`timescale 1ns/100ps

module rx_top
  (
   input  logic             clk,
   input  logic             rst,
   input  rx_pkg::set_bus_t set_i,
   input  logic [31:0]      master_time_i,
   input  logic [31:0]      sample_i,
   input  logic             strobe_i,
   output logic             run_o,
   output logic             overrun_o,
   output logic [31:0]      wr_dat_o,
   output logic             wr_write_o,
   output logic             wr_done_o,
   input  logic             wr_ready_i,
   input  logic             wr_full_i,
   output logic [15:0]      fifo_occupied_o,
   output logic             fifo_full_o,
   output logic             fifo_empty_o
   );
   import rx_pkg::*;

   rx_cmd_t cmd;
   logic    cmd_push;
   logic    clear;

   rx_settings u_rx_settings
     (
      .clk        (clk),
      .rst        (rst),
      .set_i      (set_i),
      .cmd_o      (cmd),
      .cmd_push_o (cmd_push),
      .clear_o    (clear)
      );

   rx_control #(.fifo_size(6)) u_rx_control
     (
      .clk             (clk),
      .rst             (rst),
      .cmd_i           (cmd),
      .cmd_push_i      (cmd_push),
      .clear_i         (clear),
      .master_time_i   (master_time_i),
      .sample_i        (sample_i),
      .strobe_i        (strobe_i),
      .run_o           (run_o),
      .overrun_o       (overrun_o),
      .wr_dat_o        (wr_dat_o),
      .wr_write_o      (wr_write_o),
      .wr_done_o       (wr_done_o),
      .wr_ready_i      (wr_ready_i),
      .wr_full_i       (wr_full_i),
      .fifo_occupied_o (fifo_occupied_o),
      .fifo_full_o     (fifo_full_o),
      .fifo_empty_o    (fifo_empty_o)
      );

endmodule

/* sample_fifo.sv */
`timescale 1ns/100ps

module sample_fifo
  #(parameter int depth_log2 = 10)
  (
   input  logic               clk,
   input  logic               rst,
   input  logic               clear_i,
   input  logic               write_i,
   input  rx_pkg::fifo_line_t data_i,
   input  logic               read_i,
   output rx_pkg::fifo_line_t data_o,
   output logic               full_o,
   output logic               empty_o,
   output logic [15:0]        occupied_o
   );
   import rx_pkg::*;

   fifo_line_t            mem [2**depth_log2];
   logic [depth_log2-1:0] wr_ptr;
   logic [depth_log2-1:0] rd_ptr;
   logic [depth_log2:0]   count;
   logic                  do_write;
   logic                  do_read;

   assign do_write = write_i & ~full_o;
   assign do_read  = read_i & ~empty_o;

   // Line storage
   always_ff @(posedge clk)
   begin
      if (do_write)
         mem[wr_ptr] <= data_i;
   end

   always_ff @(posedge clk)
   begin
      if (rst || clear_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (do_write)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_read)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst || clear_i)
         count <= '0;
      else if (do_write && !do_read)
         count <= count + 1'b1;
      else if (do_read && !do_write)
         count <= count - 1'b1;
   end

   assign data_o     = mem[rd_ptr];
   assign full_o     = count[depth_log2];  // Set only at exactly 2**depth_log2
   assign empty_o    = (count == '0);
   assign occupied_o = 16'(count);

   a_count_bound : assert property (@(posedge clk) disable iff (rst)
      count <= (1 << depth_log2));

endmodule

/* tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen
  #(parameter real period = 4.0,
    parameter int  rst_cycles = 16)
  (
   output logic clk_o,
   output logic rst_o
   );

   initial
   begin
      clk_o = 1'b0;
      forever #(period / 2.0) clk_o = ~clk_o;
   end

   initial
   begin
      rst_o = 1'b1;
      repeat (rst_cycles) @(posedge clk_o);
      #1 rst_o = 1'b0;  // Released off the edge like other inputs
   end

endmodule
